// ==== verilog/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'hbfc00000

// data and address width
`define CORE_WORD_WIDTH 32

// architectural general purpose registers
`define CORE_NUM_REGS 32

`endif

// ==== verilog/isa_pkg.sv ====
`include "core_settings.svh"

package isa_pkg;

    typedef logic [`CORE_WORD_WIDTH-1:0] word_t;
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        alu_addu,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_sll,
        alu_lui,
        // base plus offset for lw and sw
        alu_addr,
        alu_beq,
        alu_bne,
        alu_j
    } alu_op_t;

    // decode to execute
    typedef struct packed {
        logic     valid;
        word_t    pc;
        alu_op_t  op;
        reg_idx_t rs;
        reg_idx_t rt;
        word_t    rs_val;
        word_t    rt_val;
        word_t    imm;
        reg_idx_t dest;
        // second alu operand is imm instead of rt
        logic     use_imm;
        logic     regwrite;
        logic     memread;
        logic     memwrite;
    } decoded_t;

    // execute to result, result doubles as memory address
    typedef struct packed {
        logic     valid;
        word_t    pc;
        word_t    result;
        word_t    store_data;
        reg_idx_t dest;
        logic     regwrite;
        logic     memread;
        logic     memwrite;
    } executed_t;

endpackage

// ==== verilog/bus_pkg.sv ====
package bus_pkg;

    import isa_pkg::*;

    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } ibus_resp_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } dbus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t rdata;
    } dbus_resp_t;

endpackage

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/10ps

`include "core_settings.svh"

module fetch_unit import isa_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  logic       flush,
    input  logic       redirect,
    input  word_t      redirect_pc,
    input  ibus_resp_t iresp,
    output ibus_req_t  ireq,
    output word_t      instr,
    output word_t      instr_pc,
    output logic       instr_valid
);

    logic  running;
    word_t pc;
    word_t pending_pc;
    logic  drop;
    logic  held_valid;
    word_t held_instr;
    word_t held_pc;
    logic  done;
    logic  take;
    logic  slot_free;

    // no new request while a word waits in the skid slot
    assign ireq.valid = running & ~held_valid;
    assign ireq.addr  = pc;

    assign done      = ireq.valid & iresp.data_ok;
    assign take      = done & ~drop & ~redirect;
    assign slot_free = ~instr_valid | ~stall;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
            pc      <= `CORE_RESET_PC;
            drop    <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                if (ireq.valid && !iresp.data_ok) begin
                    // wrong-path fetch still on the bus
                    drop       <= 1'b1;
                    pending_pc <= redirect_pc;
                end else begin
                    pc <= redirect_pc;
                end
            end else if (done && drop) begin
                drop <= 1'b0;
                pc   <= pending_pc;
            end else if (take) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            instr_valid <= 1'b0;
            held_valid  <= 1'b0;
        end else if (slot_free) begin
            if (held_valid) begin
                instr       <= held_instr;
                instr_pc    <= held_pc;
                instr_valid <= 1'b1;
                held_valid  <= 1'b0;
            end else begin
                instr       <= iresp.data;
                instr_pc    <= pc;
                instr_valid <= take;
            end
        end else if (take) begin
            // decode busy, park the word
            held_instr <= iresp.data;
            held_pc    <= pc;
            held_valid <= 1'b1;
        end
    end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/10ps

`include "core_settings.svh"

module regfile import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t raddr1,
    input  reg_idx_t raddr2,
    input  logic     wen,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [`CORE_NUM_REGS];

    function automatic word_t read_port(
        input reg_idx_t addr,
        input word_t    stored,
        input logic     w_en,
        input reg_idx_t w_addr,
        input word_t    w_data
    );
        if (addr == '0) begin
            return '0;
        end
        // same-cycle write wins
        if (w_en && w_addr == addr) begin
            return w_data;
        end
        return stored;
    endfunction

    assign rdata1 = read_port(raddr1, regs[raddr1], wen, waddr, wdata);
    assign rdata2 = read_port(raddr2, regs[raddr2], wen, waddr, wdata);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== verilog/decode.sv ====
`timescale 1ns/10ps

module decode import isa_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    instr,
    input  word_t    instr_pc,
    input  logic     instr_valid,
    input  logic     hold,
    input  logic     flush,
    input  word_t    rdata1,
    input  word_t    rdata2,
    input  reg_idx_t ex_dest,
    input  logic     ex_memread,
    output reg_idx_t raddr1,
    output reg_idx_t raddr2,
    output logic     stall,
    output decoded_t decoded
);

    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;
    word_t    imm_sext;
    word_t    imm_zext;
    decoded_t dec_next;

    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm_sext = {{16{instr[15]}}, instr[15:0]};
    assign imm_zext = {16'b0, instr[15:0]};
    assign raddr1   = rs;
    assign raddr2   = rt;

    // load in execute feeding this instruction
    assign stall = instr_valid & ex_memread & (ex_dest != '0) &
                   ((ex_dest == rs) | (ex_dest == rt));

    always_comb begin
        dec_next        = '0;
        dec_next.valid  = instr_valid;
        dec_next.pc     = instr_pc;
        dec_next.rs     = rs;
        dec_next.rt     = rt;
        dec_next.rs_val = rdata1;
        dec_next.rt_val = rdata2;
        dec_next.imm    = imm_sext;
        case (instr[31:26])
            6'h00: begin
                dec_next.dest     = rd;
                dec_next.regwrite = 1'b1;
                case (instr[5:0])
                    6'h21: dec_next.op = alu_addu;
                    6'h23: dec_next.op = alu_subu;
                    6'h24: dec_next.op = alu_and;
                    6'h25: dec_next.op = alu_or;
                    6'h26: dec_next.op = alu_xor;
                    6'h2a: dec_next.op = alu_slt;
                    6'h00: begin
                        dec_next.op  = alu_sll;
                        dec_next.imm = {27'b0, instr[10:6]};
                    end
                    default: dec_next.regwrite = 1'b0;
                endcase
            end
            // addiu
            6'h09: begin
                dec_next.op       = alu_addu;
                dec_next.use_imm  = 1'b1;
                dec_next.dest     = rt;
                dec_next.regwrite = 1'b1;
            end
            // ori
            6'h0d: begin
                dec_next.op       = alu_or;
                dec_next.imm      = imm_zext;
                dec_next.use_imm  = 1'b1;
                dec_next.dest     = rt;
                dec_next.regwrite = 1'b1;
            end
            // lui
            6'h0f: begin
                dec_next.op       = alu_lui;
                dec_next.imm      = imm_zext;
                dec_next.dest     = rt;
                dec_next.regwrite = 1'b1;
            end
            // lw
            6'h23: begin
                dec_next.op       = alu_addr;
                dec_next.dest     = rt;
                dec_next.regwrite = 1'b1;
                dec_next.memread  = 1'b1;
            end
            // sw
            6'h2b: begin
                dec_next.op       = alu_addr;
                dec_next.memwrite = 1'b1;
            end
            6'h04: dec_next.op = alu_beq;
            6'h05: dec_next.op = alu_bne;
            6'h02: begin
                dec_next.op  = alu_j;
                dec_next.imm = {6'b0, instr[25:0]};
            end
            // unknown opcodes retire as no-ops
            default: dec_next.op = alu_addu;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (!hold) begin
            if (flush || stall) begin
                decoded.valid <= 1'b0;
            end else begin
                decoded <= dec_next;
            end
        end
    end

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/10ps

module execute import isa_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  decoded_t  decoded,
    input  logic      hold,
    input  logic      wb_en,
    input  reg_idx_t  wb_addr,
    input  word_t     wb_data,
    output executed_t executed,
    output logic      redirect,
    output word_t     redirect_pc,
    output reg_idx_t  ex_dest,
    output logic      ex_memread
);

    word_t     src_a;
    word_t     src_b;
    word_t     opnd_b;
    word_t     alu_out;
    word_t     branch_target;
    word_t     jump_target;
    logic      taken;
    executed_t exe_next;

    function automatic word_t forward(
        input reg_idx_t  idx,
        input word_t     reg_val,
        input executed_t er,
        input logic      w_en,
        input reg_idx_t  w_addr,
        input word_t     w_data
    );
        if (idx == '0) begin
            return reg_val;
        end
        // a load in result has no data yet, it comes through writeback
        if (er.valid && er.regwrite && !er.memread && er.dest == idx) begin
            return er.result;
        end
        if (w_en && w_addr == idx) begin
            return w_data;
        end
        return reg_val;
    endfunction

    assign src_a  = forward(decoded.rs, decoded.rs_val, executed, wb_en, wb_addr, wb_data);
    assign src_b  = forward(decoded.rt, decoded.rt_val, executed, wb_en, wb_addr, wb_data);
    assign opnd_b = decoded.use_imm ? decoded.imm : src_b;

    always_comb begin
        case (decoded.op)
            alu_addu: alu_out = src_a + opnd_b;
            alu_subu: alu_out = src_a - opnd_b;
            alu_and:  alu_out = src_a & opnd_b;
            alu_or:   alu_out = src_a | opnd_b;
            alu_xor:  alu_out = src_a ^ opnd_b;
            alu_slt:  alu_out = word_t'($signed(src_a) < $signed(opnd_b));
            alu_sll:  alu_out = src_b << decoded.imm[4:0];
            alu_lui:  alu_out = {decoded.imm[15:0], 16'b0};
            alu_addr: alu_out = src_a + decoded.imm;
            default:  alu_out = '0;
        endcase
    end

    assign branch_target = decoded.pc + 32'd4 + {decoded.imm[29:0], 2'b00};
    assign jump_target   = {decoded.pc[31:28], decoded.imm[25:0], 2'b00};

    assign taken = decoded.valid &
                   (((decoded.op == alu_beq) & (src_a == src_b)) |
                    ((decoded.op == alu_bne) & (src_a != src_b)) |
                    (decoded.op == alu_j));

    // only when the branch leaves execute, so one cycle
    assign redirect    = taken & ~hold;
    assign redirect_pc = (decoded.op == alu_j) ? jump_target : branch_target;

    assign ex_dest    = decoded.dest;
    assign ex_memread = decoded.valid & decoded.memread;

    always_comb begin
        exe_next.valid      = decoded.valid;
        exe_next.pc         = decoded.pc;
        exe_next.result     = alu_out;
        exe_next.store_data = src_b;
        exe_next.dest       = decoded.dest;
        exe_next.regwrite   = decoded.regwrite;
        exe_next.memread    = decoded.memread;
        exe_next.memwrite   = decoded.memwrite;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            executed.valid <= 1'b0;
        end else if (!hold) begin
            executed <= exe_next;
        end
    end

endmodule

// ==== verilog/result.sv ====
`timescale 1ns/10ps

module result import isa_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  executed_t  executed,
    input  dbus_resp_t dresp,
    output dbus_req_t  dreq,
    output logic       mem_busy,
    output logic       wb_en,
    output reg_idx_t   wb_addr,
    output word_t      wb_data
);

    logic mem_op;
    logic done;
    logic load_ok;

    assign mem_op = executed.valid & (executed.memread | executed.memwrite);

    // request stays up from entry until the data_ok cycle
    assign dreq.valid = mem_op & ~done;
    assign dreq.write = executed.memwrite;
    assign dreq.addr  = executed.result;
    assign dreq.wdata = executed.store_data;

    // freezes the earlier stages through the data_ok cycle
    assign mem_busy = dreq.valid;

    assign load_ok = dreq.valid & dresp.data_ok;

    // set for the single cycle the finished instruction still sits here
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= load_ok;
        end
    end

    // alu results go out while in this stage, loads in the data_ok cycle
    always_comb begin
        wb_addr = executed.dest;
        if (executed.memread) begin
            wb_en   = executed.valid & executed.regwrite & load_ok;
            wb_data = dresp.rdata;
        end else begin
            wb_en   = executed.valid & executed.regwrite;
            wb_data = executed.result;
        end
    end

endmodule

// ==== verilog/core_top.sv ====
`timescale 1ns/10ps

module core_top import isa_pkg::*, bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    output ibus_req_t  ireq,
    input  ibus_resp_t iresp,
    output dbus_req_t  dreq,
    input  dbus_resp_t dresp
);

    word_t     instr;
    word_t     instr_pc;
    logic      instr_valid;
    logic      dec_stall;
    logic      fetch_stall;
    logic      redirect;
    word_t     redirect_pc;
    reg_idx_t  raddr1;
    reg_idx_t  raddr2;
    word_t     rdata1;
    word_t     rdata2;
    decoded_t  decoded;
    executed_t executed;
    reg_idx_t  ex_dest;
    logic      ex_memread;
    logic      mem_busy;
    logic      wb_en;
    reg_idx_t  wb_addr;
    word_t     wb_data;

    assign fetch_stall = dec_stall | mem_busy;

    fetch_unit fetch_unit_inst (
        .clk         (clk),
        .reset       (reset),
        .stall       (fetch_stall),
        .flush       (redirect),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .iresp       (iresp),
        .ireq        (ireq),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

    decode decode_inst (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .hold        (mem_busy),
        .flush       (redirect),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_dest     (ex_dest),
        .ex_memread  (ex_memread),
        .raddr1      (raddr1),
        .raddr2      (raddr2),
        .stall       (dec_stall),
        .decoded     (decoded)
    );

    regfile regfile_inst (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .wen    (wb_en),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    execute execute_inst (
        .clk         (clk),
        .reset       (reset),
        .decoded     (decoded),
        .hold        (mem_busy),
        .wb_en       (wb_en),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .executed    (executed),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .ex_dest     (ex_dest),
        .ex_memread  (ex_memread)
    );

    result result_inst (
        .clk      (clk),
        .reset    (reset),
        .executed (executed),
        .dresp    (dresp),
        .dreq     (dreq),
        .mem_busy (mem_busy),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data)
    );

endmodule

// ==== bench/core_tb.sv ====
`timescale 1ns/10ps

`include "core_settings.svh"

module core_tb import isa_pkg::*, bus_pkg::*; ();

    localparam int NUM_TESTS = 8;
    localparam int BODY_LEN  = 40;
    localparam int LAST      = BODY_LEN + 31;
    localparam int MAX_CYCLES = NUM_TESTS * 120 * 6;

    logic       clk;
    logic       reset;
    ibus_req_t  ireq;
    ibus_resp_t iresp;
    dbus_req_t  dreq;
    dbus_resp_t dresp;

    word_t prog [128];
    word_t dmem [512];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    store_idx;
    int    test_errors;
    logic  checking;
    int    cycles;
    int    pass_count;
    int    fail_count;
    logic       ibusy;
    int         icnt;
    logic       dbusy;
    int         dcnt;

    core_top core_top_inst (
        .clk   (clk),
        .reset (reset),
        .ireq  (ireq),
        .iresp (iresp),
        .dreq  (dreq),
        .dresp (dresp)
    );

    always #10 clk = ~clk;

    function automatic word_t fill_word(input word_t addr);
        return addr ^ {addr[15:0], addr[15:0]} ^ 32'h6b1d0000;
    endfunction

    function automatic word_t rtype_word(input reg_idx_t rs, input reg_idx_t rt,
                                         input reg_idx_t rd, input logic [4:0] sa,
                                         input logic [5:0] fn);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t itype_word(input logic [5:0] op, input reg_idx_t rs,
                                         input reg_idx_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype_word(input word_t target);
        return {6'h02, target[27:2]};
    endfunction

    function automatic reg_idx_t pick_reg();
        return reg_idx_t'($urandom_range(0, 9));
    endfunction

    // forward-only branches and jumps, memory ops based on r0
    task automatic make_program();
        int          kind;
        int          span;
        int          tgt;
        reg_idx_t    s;
        reg_idx_t    t;
        reg_idx_t    d;
        logic [15:0] imm;
        logic [15:0] maddr;
        for (int i = 0; i < 128; i++) begin
            prog[i] = '0;
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            kind  = int'($urandom_range(0, 16));
            s     = pick_reg();
            t     = pick_reg();
            d     = pick_reg();
            imm   = 16'($urandom());
            maddr = 16'(4 * $urandom_range(0, 255));
            span  = BODY_LEN - 1 - i;
            if (span > 4) begin
                span = 4;
            end
            case (kind)
                0: prog[i] = rtype_word(s, t, d, 5'd0, 6'h21);
                1: prog[i] = rtype_word(s, t, d, 5'd0, 6'h23);
                2: prog[i] = rtype_word(s, t, d, 5'd0, 6'h24);
                3: prog[i] = rtype_word(s, t, d, 5'd0, 6'h25);
                4: prog[i] = rtype_word(s, t, d, 5'd0, 6'h26);
                5: prog[i] = rtype_word(s, t, d, 5'd0, 6'h2a);
                6: prog[i] = rtype_word(s, t, d, imm[4:0], 6'h00);
                7: prog[i] = itype_word(6'h09, s, t, imm);
                8: prog[i] = itype_word(6'h0d, s, t, imm);
                9: prog[i] = itype_word(6'h0f, 5'd0, t, imm);
                10, 15: prog[i] = itype_word(6'h23, 5'd0, t, maddr);
                11, 16: prog[i] = itype_word(6'h2b, 5'd0, t, maddr);
                12: prog[i] = itype_word(6'h04, s, t, 16'($urandom_range(0, span)));
                13: prog[i] = itype_word(6'h05, s, t, 16'($urandom_range(0, span)));
                default: begin
                    tgt     = i + 1 + int'($urandom_range(0, span));
                    prog[i] = jtype_word(`CORE_RESET_PC + word_t'(tgt * 4));
                end
            endcase
        end
        // register dump, then spin
        for (int r = 1; r < 32; r++) begin
            prog[BODY_LEN + r - 1] = itype_word(6'h2b, 5'd0, reg_idx_t'(r),
                                                16'h0400 + 16'(4 * (r - 1)));
        end
        prog[LAST] = jtype_word(`CORE_RESET_PC + word_t'(LAST * 4));
    endtask

    // ISA model without delay slots, fills the expected store list
    function automatic void run_model();
        word_t    regs [`CORE_NUM_REGS];
        word_t    mem [512];
        word_t    pc;
        word_t    npc;
        word_t    ins;
        word_t    a;
        word_t    b;
        word_t    sx;
        word_t    zx;
        word_t    addr;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < `CORE_NUM_REGS; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 512; i++) begin
            mem[i] = fill_word(word_t'(i) << 2);
        end
        pc = `CORE_RESET_PC;
        for (int step = 0; step < 2000; step++) begin
            if (pc == `CORE_RESET_PC + word_t'(LAST * 4)) begin
                break;
            end
            ins  = prog[7'((pc - `CORE_RESET_PC) >> 2)];
            rs   = ins[25:21];
            rt   = ins[20:16];
            rd   = ins[15:11];
            a    = regs[rs];
            b    = regs[rt];
            sx   = {{16{ins[15]}}, ins[15:0]};
            zx   = {16'b0, ins[15:0]};
            addr = a + sx;
            npc  = pc + 32'd4;
            case (ins[31:26])
                6'h00: begin
                    case (ins[5:0])
                        6'h21: regs[rd] = a + b;
                        6'h23: regs[rd] = a - b;
                        6'h24: regs[rd] = a & b;
                        6'h25: regs[rd] = a | b;
                        6'h26: regs[rd] = a ^ b;
                        6'h2a: regs[rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h00: regs[rd] = b << ins[10:6];
                        default: ;
                    endcase
                end
                6'h09: regs[rt] = a + sx;
                6'h0d: regs[rt] = a | zx;
                6'h0f: regs[rt] = {ins[15:0], 16'b0};
                6'h23: regs[rt] = mem[addr[10:2]];
                6'h2b: begin
                    mem[addr[10:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                6'h04: if (a == b) npc = npc + (sx << 2);
                6'h05: if (a != b) npc = npc + (sx << 2);
                6'h02: npc = {pc[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            regs[0] = '0;
            pc = npc;
        end
    endfunction

    // instruction memory, 1 to 4 cycles per request
    always @(posedge clk) begin
        word_t off;
        off = ireq.addr - `CORE_RESET_PC;
        iresp.data_ok <= 1'b0;
        if (reset) begin
            ibusy <= 1'b0;
        end else if (ibusy) begin
            if (icnt == 0) begin
                iresp.data_ok <= 1'b1;
                iresp.data    <= (off < 32'd512) ? prog[off[8:2]] : 32'h0;
                ibusy         <= 1'b0;
            end else begin
                icnt <= icnt - 1;
            end
        end else if (ireq.valid && !iresp.data_ok) begin
            ibusy <= 1'b1;
            icnt  <= int'($urandom_range(0, 3));
        end
    end

    // data memory
    always @(posedge clk) begin
        dresp.data_ok <= 1'b0;
        if (reset) begin
            dbusy <= 1'b0;
            for (int i = 0; i < 512; i++) begin
                dmem[i] <= fill_word(word_t'(i) << 2);
            end
        end else if (dbusy) begin
            if (dcnt == 0) begin
                dresp.data_ok <= 1'b1;
                dresp.rdata   <= dmem[dreq.addr[10:2]];
                if (dreq.write) begin
                    dmem[dreq.addr[10:2]] <= dreq.wdata;
                end
                dbusy <= 1'b0;
            end else begin
                dcnt <= dcnt - 1;
            end
        end else if (dreq.valid && !dresp.data_ok) begin
            dbusy <= 1'b1;
            dcnt  <= int'($urandom_range(0, 3));
        end
    end

    // completed stores against the model, in order
    always @(negedge clk) begin
        if (checking && dreq.valid && dreq.write && dresp.data_ok) begin
            assert (store_idx < exp_addr.size()) else begin
                $display("unexpected store to address %h beyond the model's %0d stores",
                         dreq.addr, exp_addr.size());
                test_errors++;
            end
            if (store_idx < exp_addr.size()) begin
                assert (dreq.addr == exp_addr[store_idx]) else begin
                    $display("[ERROR] dreq.addr expected %h actual %h",
                             exp_addr[store_idx], dreq.addr);
                    test_errors++;
                end
                assert (dreq.wdata == exp_data[store_idx]) else begin
                    $display("[ERROR] dreq.wdata expected %h actual %h",
                             exp_data[store_idx], dreq.wdata);
                    test_errors++;
                end
                store_idx++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the core stopped storing after %0d of %0d stores",
                     store_idx, exp_addr.size());
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        clk         = 1'b0;
        reset       <= 1'b1;
        iresp       <= '0;
        dresp       <= '0;
        checking    = 1'b0;
        store_idx   = 0;
        test_errors = 0;
        cycles      = 0;
        pass_count  = 0;
        fail_count  = 0;
        void'($urandom(97155));
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(posedge clk);
            reset <= 1'b1;
            make_program();
            run_model();
            store_idx   = 0;
            test_errors = 0;
            for (int c = 0; c < 10; c++) begin
                @(negedge clk);
                // synchronous reset takes hold at the first reset edge
                if (c > 0) begin
                    assert (!ireq.valid && !dreq.valid) else begin
                        $display("a bus request was raised while reset was high");
                        test_errors++;
                    end
                end
                @(posedge clk);
            end
            reset    <= 1'b0;
            checking = 1'b1;
            @(negedge clk);
            while (!ireq.valid) begin
                @(negedge clk);
            end
            assert (ireq.addr == `CORE_RESET_PC) else begin
                $display("[ERROR] ireq.addr expected %h actual %h",
                         `CORE_RESET_PC, ireq.addr);
                test_errors++;
            end
            while (store_idx < exp_addr.size()) begin
                @(negedge clk);
            end
            // extra stores would show up here
            repeat (30) @(negedge clk);
            checking = 1'b0;
            if (test_errors == 0) begin
                pass_count++;
            end else begin
                fail_count++;
            end
            $display("test %0d: %0d of %0d stores, %0d errors", t, store_idx,
                     exp_addr.size(), test_errors);
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/bus_pkg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/core_top.sv
bench/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module core_tb -o core_tb_sim

out=$(./obj_dir/core_tb_sim)
echo "$out"

if echo "$out" | grep -q "^RESULT: PASS$"; then
    exit 0
else
    exit 1
fi
